// ==== all.f ====
+incdir+hw
hw/cluster_pkg.sv
hw/desc_if.sv
hw/pipe_reg.sv
hw/arith_engine.sv
hw/engine_slot.sv
hw/desc_dispatch.sv
hw/result_collect.sv
hw/cluster_top.sv
tests/cluster_assert.sv
tests/cluster_tb.sv

// ==== hw/arith_engine.sv ====
`default_nettype none

`include "cluster_params.svh"

module arith_engine
  import cluster_pkg::*;
(
  input  logic clk,
  input  logic rst,
  desc_if.dst  desc_in,
  desc_if.src  res_out
);

  localparam int STEP_W = $clog2(`MUL_STEPS);

  eng_state_e        state;
  desc_t             cur;
  logic              accept;
  logic [7:0]        tag_q;
  logic [31:0]       value_q;
  logic [31:0]       mcand_q;
  logic [15:0]       mplier_q;
  logic [STEP_W-1:0] step_q;

  assign cur             = desc_in.payload;
  assign desc_in.ready   = (state == ST_IDLE);
  assign accept          = desc_in.valid && desc_in.ready;
  assign res_out.valid   = (state == ST_DONE);
  assign res_out.payload = {tag_q, value_q};

  ////////////////////
  // FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= (cur.op == OP_MUL) ? ST_MUL : ST_DONE;
          end
        end
        ST_MUL: begin
          if (step_q == STEP_W'(`MUL_STEPS - 1)) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (res_out.ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q    <= cur.tag;
      mcand_q  <= {16'h0, cur.arg_a};
      mplier_q <= cur.arg_b;
      step_q   <= '0;
      case (cur.op)
        OP_ADD:  value_q <= {16'h0, cur.arg_a} + {16'h0, cur.arg_b};
        OP_XOR:  value_q <= {16'h0, cur.arg_a ^ cur.arg_b};
        OP_CAT:  value_q <= {cur.arg_a, cur.arg_b};
        // Multiply accumulates from zero
        default: value_q <= '0;
      endcase
    end else if (state == ST_MUL) begin
      value_q  <= value_q + (mplier_q[0] ? mcand_q : 32'h0);
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      step_q   <= step_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cluster_params.svh ====
`ifndef CLUSTER_PARAMS_SVH
`define CLUSTER_PARAMS_SVH

// Number of engine slots in the cluster
`define NUM_SLOTS 4

// Shift-add steps of the multiply, one per operand bit
`define MUL_STEPS 16

`endif

// ==== hw/cluster_pkg.sv ====
`default_nettype none

package cluster_pkg;

  `include "cluster_params.svh"

  localparam int SLOT_W = (`NUM_SLOTS > 1) ? $clog2(`NUM_SLOTS) : 1;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_XOR,
    OP_CAT,
    OP_MUL
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_DONE
  } eng_state_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  tag;
    logic [15:0] arg_a;
    logic [15:0] arg_b;
  } desc_t;

  typedef struct packed {
    logic [7:0]  tag;
    logic [31:0] value;
  } result_t;

  // First requester at or after ptr, wrapping around
  function automatic logic [SLOT_W-1:0] rr_pick(input logic [`NUM_SLOTS-1:0] req,
                                                input logic [SLOT_W-1:0]     ptr);
    logic [SLOT_W-1:0] pick;
    logic              hit;
    int                idx;
    pick = ptr;
    hit  = 1'b0;
    for (int k = 0; k < `NUM_SLOTS; k++) begin
      idx = (int'(ptr) + k) % `NUM_SLOTS;
      if (!hit && req[idx]) begin
        pick = SLOT_W'(idx);
        hit  = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic logic [SLOT_W-1:0] rr_next(input logic [SLOT_W-1:0] idx);
    return (idx == SLOT_W'(`NUM_SLOTS - 1)) ? '0 : idx + 1'b1;
  endfunction

endpackage

`default_nettype wire

// ==== hw/cluster_top.sv ====
`default_nettype none

`include "cluster_params.svh"

module cluster_top
  import cluster_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              in_valid,
  output logic              in_ready,
  input  op_e               in_op,
  input  logic [7:0]        in_tag,
  input  logic [15:0]       in_arg_a,
  input  logic [15:0]       in_arg_b,

  output logic              out_valid,
  input  logic              out_ready,
  output logic [7:0]        out_tag,
  output logic [31:0]       out_value,
  output logic [SLOT_W-1:0] out_slot
);

  desc_t   in_desc;
  result_t out_res;

  assign in_desc   = '{op: in_op, tag: in_tag, arg_a: in_arg_a, arg_b: in_arg_b};
  assign out_tag   = out_res.tag;
  assign out_value = out_res.value;

  desc_if #(.T(desc_t))   slot_desc [`NUM_SLOTS] ();
  desc_if #(.T(result_t)) slot_res  [`NUM_SLOTS] ();

  desc_dispatch dispatch_inst (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_desc (in_desc),
    .slot_out(slot_desc)
  );

  ////////////////////
  // Engine slots
  ////////////////////
  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : g_slot
    engine_slot slot_inst (
      .clk    (clk),
      .rst    (rst),
      .desc_in(slot_desc[i]),
      .res_out(slot_res[i])
    );
  end

  result_collect collect_inst (
    .clk      (clk),
    .rst      (rst),
    .slot_in  (slot_res),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_res  (out_res),
    .out_slot (out_slot)
  );

endmodule

`default_nettype wire

// ==== hw/desc_dispatch.sv ====
`default_nettype none

`include "cluster_params.svh"

module desc_dispatch
  import cluster_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  logic  in_valid,
  output logic  in_ready,
  input  desc_t in_desc,

  desc_if.src   slot_out [`NUM_SLOTS]
);

  logic [`NUM_SLOTS-1:0] rdy;
  logic [SLOT_W-1:0]     ptr;
  logic [SLOT_W-1:0]     sel;

  assign sel      = rr_pick(rdy, ptr);
  assign in_ready = |rdy;

  // Only the selected slot sees valid
  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : g_route
    assign rdy[i]              = slot_out[i].ready;
    assign slot_out[i].valid   = in_valid && in_ready && (sel == SLOT_W'(i));
    assign slot_out[i].payload = in_desc;
  end

  ////////////////////
  // Pointer
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (in_valid && in_ready) begin
      ptr <= rr_next(sel);
    end
  end

endmodule

`default_nettype wire

// ==== hw/desc_if.sv ====
`default_nettype none

// One valid/ready channel; payload type set per instance
interface desc_if
  import cluster_pkg::*;
#(
  parameter type T = desc_t
);

  logic valid;
  logic ready;
  T     payload;

  modport src (
    output valid,
    output payload,
    input  ready
  );

  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== hw/engine_slot.sv ====
`default_nettype none

module engine_slot
  import cluster_pkg::*;
(
  input  logic clk,
  input  logic rst,
  desc_if.dst  desc_in,
  desc_if.src  res_out
);

  // Local copy of reset for this slot
  logic rst_r;

  always_ff @(posedge clk) begin
    rst_r <= rst;
  end

  desc_if #(.T(desc_t))   eng_in ();
  desc_if #(.T(result_t)) eng_out ();

  ////////////////////
  // Input slice
  ////////////////////
  pipe_reg #(
    .WIDTH($bits(desc_t))
  ) in_reg (
    .clk    (clk),
    .rst    (rst_r),
    .s_data (desc_in.payload),
    .s_valid(desc_in.valid),
    .s_ready(desc_in.ready),
    .m_data (eng_in.payload),
    .m_valid(eng_in.valid),
    .m_ready(eng_in.ready)
  );

  arith_engine engine_inst (
    .clk    (clk),
    .rst    (rst_r),
    .desc_in(eng_in.dst),
    .res_out(eng_out.src)
  );

  ////////////////////
  // Output slice
  ////////////////////
  pipe_reg #(
    .WIDTH($bits(result_t))
  ) out_reg (
    .clk    (clk),
    .rst    (rst_r),
    .s_data (eng_out.payload),
    .s_valid(eng_out.valid),
    .s_ready(eng_out.ready),
    .m_data (res_out.payload),
    .m_valid(res_out.valid),
    .m_ready(res_out.ready)
  );

endmodule

`default_nettype wire

// ==== hw/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,

  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,

  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data;
  logic             main_load;

  // Main entry can take new data
  assign main_load = !m_valid || m_ready;

  ////////////////////
  // Control
  ////////////////////
  // Skid entry is full exactly when s_ready is low
  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      s_ready <= 1'b1;
    end else begin
      if (main_load) begin
        m_valid <= !s_ready || s_valid;
        s_ready <= 1'b1;
      end else if (s_valid && s_ready) begin
        s_ready <= 1'b0;
      end
    end
  end

  ////////////////////
  // Data
  ////////////////////
  always_ff @(posedge clk) begin
    if (main_load) begin
      m_data <= s_ready ? s_data : skid_data;
    end
    if (s_ready) begin
      skid_data <= s_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/result_collect.sv ====
`default_nettype none

`include "cluster_params.svh"

module result_collect
  import cluster_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  desc_if.dst               slot_in [`NUM_SLOTS],

  output logic              out_valid,
  input  logic              out_ready,
  output result_t           out_res,
  output logic [SLOT_W-1:0] out_slot
);

  logic [`NUM_SLOTS-1:0] vld;
  result_t               res [`NUM_SLOTS];
  logic [SLOT_W-1:0]     ptr;
  logic [SLOT_W-1:0]     grant;
  logic                  any;
  logic                  load;

  assign grant = rr_pick(vld, ptr);
  assign any   = |vld;
  // Output register empty or draining this cycle
  assign load  = !out_valid || out_ready;

  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : g_req
    assign vld[i]            = slot_in[i].valid;
    assign res[i]            = slot_in[i].payload;
    assign slot_in[i].ready  = load && any && (grant == SLOT_W'(i));
  end

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else if (load) begin
      out_valid <= any;
      if (any) begin
        ptr <= rr_next(grant);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && any) begin
      out_res  <= res[grant];
      out_slot <= grant;
    end
  end

endmodule

`default_nettype wire

// ==== tests/cluster_assert.sv ====
`default_nettype none

`include "cluster_params.svh"

module cluster_assert
  import cluster_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              in_ready,
  input logic              out_valid,
  input logic              out_ready,
  input logic [7:0]        out_tag,
  input logic [31:0]       out_value,
  input logic [SLOT_W-1:0] out_slot
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int STALL_LIMIT = `MUL_STEPS + 8;

  // Output register empty through reset and one cycle beyond
  out_idle_in_reset: assert property (@(posedge clk) rst || $past(rst) |=> !out_valid)
    else $error("out_valid high during or right after reset");

  out_stable_on_stall: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=>
      out_valid && $stable(out_tag) && $stable(out_value) && $stable(out_slot))
    else $error("Stalled output changed or dropped");

  // Slots drain while the output is open
  in_ready_recovers: assert property (@(posedge clk) disable iff (rst)
    (!in_ready && out_ready) [*STALL_LIMIT] |=> (in_ready || !out_ready))
    else $error("in_ready stuck low while out_ready held high");

endmodule

bind cluster_top cluster_assert cluster_assert_inst (.*);

`default_nettype wire

// ==== tests/cluster_tb.sv ====
`default_nettype none

`include "cluster_params.svh"

module cluster_tb
  import cluster_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TEST_LEN    = 40;
  localparam int TOTAL_DESCS = 3 * TEST_LEN + `NUM_SLOTS;
  localparam int CYCLE_LIMIT = TOTAL_DESCS * (`MUL_STEPS + 10) * `NUM_SLOTS;

  // Opcode mixes
  localparam int MIX_SHORT = 0;
  localparam int MIX_ALL   = 1;
  localparam int MIX_MUL   = 2;

  logic              clk = 1'b0;
  logic              rst;
  logic              in_valid;
  logic              in_ready;
  op_e               in_op;
  logic [7:0]        in_tag;
  logic [15:0]       in_arg_a;
  logic [15:0]       in_arg_b;
  logic              out_valid;
  logic              out_ready;
  logic [7:0]        out_tag;
  logic [31:0]       out_value;
  logic [SLOT_W-1:0] out_slot;

  logic [31:0]       rng;
  int                cycles = 0;
  int                errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  // Model state, indexed by tag
  result_t           model   [256];
  bit                issued  [256];
  bit                seen    [256];
  logic [SLOT_W-1:0] slot_of [256];

  always #20 clk = ~clk;

  cluster_top cluster_top_inst (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_op    (in_op),
    .in_tag   (in_tag),
    .in_arg_a (in_arg_a),
    .in_arg_b (in_arg_b),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_tag  (out_tag),
    .out_value(out_value),
    .out_slot (out_slot)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: no progress after %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Model
  ////////////////////
  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic logic [31:0] expected_value(input op_e op, input logic [15:0] a,
                                                 input logic [15:0] b);
    case (op)
      OP_ADD:  return 32'(a) + 32'(b);
      OP_XOR:  return 32'(a ^ b);
      OP_CAT:  return {a, b};
      default: return 32'(a) * 32'(b);
    endcase
  endfunction

  task automatic compare_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected tag %0d value %h, actual tag %0d value %h",
               name, exp.tag, exp.value, act.tag, act.value);
    end
  endtask

  task automatic compare_slot(input string name, input logic [SLOT_W-1:0] exp,
                              input logic [SLOT_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected slot %0d, actual slot %0d", name, exp, act);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic drive_desc(input int tag, input int mode);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    op_e         op;
    r = lcg_next();
    a = lcg_next();
    b = lcg_next();
    case (mode)
      MIX_SHORT: op = op_e'(2'(r[31:16] % 3));
      MIX_ALL:   op = r[31] ? OP_MUL : op_e'(2'(r[30:16] % 3));
      default:   op = OP_MUL;
    endcase
    model[tag]  = '{tag: 8'(tag), value: expected_value(op, a[31:16], b[31:16])};
    issued[tag] = 1'b1;
    in_valid <= 1'b1;
    in_op    <= op;
    in_tag   <= 8'(tag);
    in_arg_a <= a[31:16];
    in_arg_b <= b[31:16];
  endtask

  task automatic check_output(input string name);
    int tag;
    tag = int'(out_tag);
    if ($isunknown(out_slot) || int'(out_slot) >= `NUM_SLOTS) begin
      errors++;
      $display("%s: result came from slot %0d, which is not a valid slot", name, out_slot);
    end
    if (!issued[tag]) begin
      errors++;
      $display("%s: result carries tag %0d, which was never issued", name, tag);
    end else if (seen[tag]) begin
      errors++;
      $display("%s: tag %0d came back a second time", name, tag);
    end else begin
      seen[tag]    = 1'b1;
      slot_of[tag] = out_slot;
      compare_result(name, model[tag], result_t'({out_tag, out_value}));
    end
  endtask

  task automatic check_idle(input string name);
    int errs_before;
    errs_before = errors;
    do @(posedge clk); while (!in_ready);
    repeat (16) begin
      @(posedge clk);
      if (out_valid) begin
        errors++;
        $display("%s: out_valid rose with no descriptor sent", name);
      end
    end
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("%-12s %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  task automatic run_test(input string name, input int n, input int mode, input bit stall);
    int          sent;
    int          got;
    int          errs_before;
    logic        xfer;
    logic [31:0] r;
    sent = 0;
    got = 0;
    errs_before = errors;
    for (int t = 0; t < 256; t++) begin
      issued[t] = 1'b0;
      seen[t]   = 1'b0;
    end
    while (got < n) begin
      @(posedge clk);
      xfer = in_valid && in_ready;
      if (xfer) sent++;
      if (out_valid && out_ready) begin
        check_output(name);
        got++;
      end
      if (sent < n && (xfer || !in_valid)) begin
        drive_desc(sent, mode);
      end else if (xfer) begin
        in_valid <= 1'b0;
      end
      r = lcg_next();
      out_ready <= stall ? r[29] : 1'b1;
    end
    out_ready <= 1'b1;
    for (int t = 0; t < n; t++) begin
      if (!seen[t]) begin
        errors++;
        $display("%s: tag %0d never came back", name, t);
      end
    end
    // Idle slots take a burst in round-robin order
    if (mode == MIX_MUL) begin
      for (int k = 1; k < n; k++) begin
        compare_slot(name, SLOT_W'((int'(slot_of[0]) + k) % `NUM_SLOTS), slot_of[k]);
      end
    end
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("%-12s %s: %0d results, %0d errors", name,
             (errors == errs_before) ? "ok" : "FAILED", got, errors - errs_before);
  endtask

  initial begin
    rng       = 32'd21175;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_op     = OP_ADD;
    in_tag    = '0;
    in_arg_a  = '0;
    in_arg_b  = '0;
    out_ready = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    check_idle("reset_idle");
    run_test("short_ops", TEST_LEN, MIX_SHORT, 1'b0);
    run_test("mul_mix", TEST_LEN, MIX_ALL, 1'b0);
    run_test("backpressure", TEST_LEN, MIX_ALL, 1'b1);
    run_test("mul_burst", `NUM_SLOTS, MIX_MUL, 1'b0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
